/* bench/te_tb.sv */
// trace encoder testbench
// drives a table of retirement steps into te_top, checks every packet
// against the expected list in order and its stability under back-pressure
`timescale 1ns/1ps
`include "te_params.svh"

module te_tb;
    import te_pkg::*;

    localparam int NSTEPS = 125;

    typedef struct {
        logic                   valid;
        logic                   en;
        logic [`TE_IADDR_W-1:0] addr;
        logic                   exc;
        logic [`TE_CAUSE_W-1:0] cause;
        logic                   upd;
        logic                   br;
        logic                   taken;
        logic                   rnd;
        logic                   has_exp;
        te_packet_t             exp;
    } step_t;

    logic clk_i = 1'b0;
    logic rst_ni = 1'b0;
    logic enc_enable_i = 1'b0;
    logic iretire_valid_i = 1'b0;
    logic iretire_ready_o;
    logic [`TE_IADDR_W-1:0] iaddr_i = '0;
    logic iexception_i = 1'b0;
    logic [`TE_CAUSE_W-1:0] icause_i = '0;
    logic iprivchange_i = 1'b0;
    logic iupdiscon_i = 1'b0;
    logic ibranch_i = 1'b0;
    logic itaken_i = 1'b0;
    logic pkt_valid_o;
    logic pkt_ready_i = 1'b1;
    te_packet_t cur;
    te_packet_t held;
    logic hold_q = 1'b0;
    logic rnd_mode = 1'b0;
    step_t tbl [NSTEPS];
    te_packet_t exp_q [$];
    int errors = 0;
    int n_pass = 0;
    int n_fail = 0;

    te_top dut0 (
        .clk_i(clk_i), .rst_ni(rst_ni), .enc_enable_i(enc_enable_i),
        .iretire_valid_i(iretire_valid_i), .iretire_ready_o(iretire_ready_o),
        .iaddr_i(iaddr_i), .iexception_i(iexception_i), .icause_i(icause_i),
        .iprivchange_i(iprivchange_i), .iupdiscon_i(iupdiscon_i),
        .ibranch_i(ibranch_i), .itaken_i(itaken_i),
        .pkt_valid_o(pkt_valid_o), .pkt_ready_i(pkt_ready_i),
        .pkt_format_o(cur.format), .pkt_subformat_o(cur.subformat),
        .pkt_thaddr_o(cur.thaddr), .pkt_qual_o(cur.qual),
        .pkt_addr_o(cur.addr), .pkt_cause_o(cur.cause),
        .pkt_bcount_o(cur.bcount), .pkt_bmap_o(cur.bmap)
    );

    always #4 clk_i = ~clk_i;

    // instruction k sits at its own address, bubble at zero
    function automatic logic [`TE_IADDR_W-1:0] addr_of(input int k);
        return (k == 0) ? '0 : 32'h8000_0000 + (32'(k) << 2);
    endfunction

    function automatic logic [`TE_CAUSE_W-1:0] cause_of(input int k);
        return (k == 43) ? 5'd5 : (k == 44) ? 5'd7 : 5'd0;
    endfunction

    function automatic logic taken_of(input int k);
        return (k == 6) || (k >= 10 && k <= 40 && (k % 3) != 0);
    endfunction

    task automatic set_exp(input int k, input te_format_e f, input te_sync_sf_e sf,
                           input logic th, input int src, input int bcnt,
                           input logic [`TE_BMAP_W-1:0] map);
        tbl[k].has_exp        = 1'b1;
        tbl[k].exp.format     = f;
        tbl[k].exp.subformat  = sf;
        tbl[k].exp.thaddr     = th;
        tbl[k].exp.qual       = NO_CHANGE;
        tbl[k].exp.addr       = addr_of(src);
        tbl[k].exp.cause      = cause_of(src);
        tbl[k].exp.bcount     = 5'(bcnt);
        tbl[k].exp.bmap       = map;
    endtask

    task automatic build_table();
        logic [`TE_BMAP_W-1:0] full_map;
        for (int k = 0; k < NSTEPS; k++) begin
            // step 0 is the enable edge bubble
            tbl[k].valid   = (k != 0);
            tbl[k].en      = 1'b1;
            tbl[k].addr    = addr_of(k);
            tbl[k].exc     = (k == 43) || (k == 44);
            tbl[k].cause   = cause_of(k);
            tbl[k].upd     = (k == 4) || (k == 8) || (k >= 113 && k <= 120);
            tbl[k].br      = (k == 6) || (k == 7) || (k >= 10 && k <= 40);
            tbl[k].taken   = taken_of(k);
            tbl[k].rnd     = (k >= 113);
            tbl[k].has_exp = 1'b0;
            tbl[k].exp     = '0;
        end
        // oldest branch in bit 0
        for (int j = 0; j < `TE_BMAP_W; j++) begin
            full_map[j] = taken_of(10 + j);
        end
        // a packet for instruction k is captured when k+2 transfers
        set_exp(2, F_SYNC, SF_SUPPORT, 1'b0, 0, 0, '0);
        set_exp(3, F_SYNC, SF_START, 1'b0, 1, 0, '0);
        set_exp(7, F_ADDR_ONLY, SF_START, 1'b0, 5, 0, '0);
        set_exp(11, F_DIFF_DELTA, SF_START, 1'b0, 9, 2, 31'h1);
        set_exp(42, F_DIFF_DELTA, SF_START, 1'b0, 40, 31, full_map);
        set_exp(44, F_ADDR_ONLY, SF_START, 1'b0, 42, 0, '0);
        set_exp(45, F_ADDR_ONLY, SF_START, 1'b0, 43, 0, '0);
        // trap reports the faulting instruction in lc
        set_exp(46, F_SYNC, SF_TRAP, 1'b0, 43, 0, '0);
        set_exp(47, F_SYNC, SF_START, 1'b0, 45, 0, '0);
        // resync limit reached with no packet since 45
        set_exp(112, F_SYNC, SF_START, 1'b0, 110, 0, '0);
        for (int k = 116; k <= 123; k++) begin
            set_exp(k, F_ADDR_ONLY, SF_START, 1'b0, k - 2, 0, '0);
        end
    endtask

    task automatic check_kind(input te_packet_t got, input te_packet_t exp);
        if (got.format !== exp.format) begin
            errors++;
            $display("error at %0d ns: pkt_format_o got %s expected %s",
                     $time, got.format.name(), exp.format.name());
        end
        if (got.subformat !== exp.subformat) begin
            errors++;
            $display("error at %0d ns: pkt_subformat_o got %s expected %s",
                     $time, got.subformat.name(), exp.subformat.name());
        end
        if (got.qual !== exp.qual || got.thaddr !== exp.thaddr) begin
            errors++;
            $display("error at %0d ns: pkt_qual_o/pkt_thaddr_o got %s/%b expected %s/%b",
                     $time, got.qual.name(), got.thaddr, exp.qual.name(), exp.thaddr);
        end
    endtask

    task automatic check_word(input string sig, input logic [31:0] got,
                              input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("error at %0d ns: %s got %h expected %h", $time, sig, got, exp);
        end
    endtask

    task automatic check_branches(input te_packet_t got, input te_packet_t exp);
        if (got.bcount !== exp.bcount || got.bmap !== exp.bmap) begin
            errors++;
            $display("error at %0d ns: pkt_bcount_o/pkt_bmap_o got %0d/%h expected %0d/%h",
                     $time, got.bcount, got.bmap, exp.bcount, exp.bmap);
        end
    endtask

    task automatic compare_packet(input te_packet_t got, input te_packet_t exp);
        check_kind(got, exp);
        check_word("pkt_addr_o", got.addr, exp.addr);
        check_word("pkt_cause_o", 32'(got.cause), 32'(exp.cause));
        check_branches(got, exp);
    endtask

    // sink ready, random only in the back-pressure phase
    initial begin : ready_gen
        logic [31:0] r;
        r = $urandom(32'h0f8678dc);
        forever begin
            @(posedge clk_i);
            if (rnd_mode) begin
                r = $urandom();
                pkt_ready_i <= r[0];
            end else begin
                pkt_ready_i <= 1'b1;
            end
        end
    end

    // output side sampled mid-cycle, away from the driving edge
    always @(negedge clk_i) begin : monitor
        int e0;
        // input side may only stall behind a held packet
        if (!iretire_ready_o && !(pkt_valid_o && !pkt_ready_i)) begin
            errors++;
            $display("error at %0d ns: iretire_ready_o got %b expected %b",
                     $time, iretire_ready_o, 1'b1);
        end
        if (hold_q) begin
            if (!pkt_valid_o) begin
                errors++;
                $display("packet withdrawn at %0d ns before it was accepted", $time);
            end else begin
                compare_packet(cur, held);
            end
        end
        if (pkt_valid_o && pkt_ready_i) begin
            if (exp_q.size() == 0) begin
                errors++;
                n_fail++;
                $display("unexpected extra packet at %0d ns", $time);
            end else begin
                e0 = errors;
                compare_packet(cur, exp_q.pop_front());
                if (errors == e0) begin
                    n_pass++;
                end else begin
                    n_fail++;
                end
                $display("packet %0d: %s", n_pass + n_fail, (errors == e0) ? "ok" : "mismatch");
            end
        end
        hold_q <= pkt_valid_o && !pkt_ready_i;
        held   <= cur;
    end

    initial begin : watchdog
        #(NSTEPS * 20 * 8);
        $display("timeout: packets still missing after %0d cycles", NSTEPS * 20);
        $display("Simulation failed");
        $finish;
    end

    initial begin : driver
        logic accepted;
        build_table();
        repeat (3) @(posedge clk_i);
        rst_ni <= 1'b1;
        @(posedge clk_i);
        for (int i = 0; i < NSTEPS; i++) begin
            if (tbl[i].has_exp) begin
                exp_q.push_back(tbl[i].exp);
            end
            rnd_mode        <= tbl[i].rnd;
            enc_enable_i    <= tbl[i].en;
            iretire_valid_i <= tbl[i].valid;
            iaddr_i         <= tbl[i].addr;
            iexception_i    <= tbl[i].exc;
            icause_i        <= tbl[i].cause;
            iupdiscon_i     <= tbl[i].upd;
            ibranch_i       <= tbl[i].br;
            itaken_i        <= tbl[i].taken;
            // hold the step until the encoder takes it
            do begin
                @(negedge clk_i);
                accepted = iretire_ready_o;
                @(posedge clk_i);
            end while (!accepted);
        end
        iretire_valid_i <= 1'b0;
        rnd_mode        <= 1'b0;
        while (exp_q.size() != 0) begin
            @(posedge clk_i);
        end
        repeat (10) @(posedge clk_i);
        $display("tests: %0d, passed: %0d, failed: %0d", n_pass + n_fail, n_pass, n_fail);
        if (errors == 0 && n_fail == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* flist.f */
+incdir+rtl
rtl/te_pkg.sv
rtl/te_hist_if.sv
rtl/te_hist_pipe.sv
rtl/te_branch_map.sv
rtl/te_resync_cnt.sv
rtl/te_priority.sv
rtl/te_packet_emitter.sv
rtl/te_top.sv
bench/te_tb.sv

/* rtl/te_branch_map.sv */
// branch map
// records the taken bit of every branch reaching tc, oldest in bit 0,
// and restarts when a packet consumes the map
`timescale 1ns/1ps
`include "te_params.svh"

module te_branch_map (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    input  logic                  advance_i,
    input  logic                  ibranch_i,
    input  logic                  itaken_i,
    input  logic                  flush_i,
    output logic                  empty_o,
    output logic                  full_o,
    output logic [`TE_BCNT_W-1:0] count_o,
    output logic [`TE_BMAP_W-1:0] map_o
);

    localparam logic [`TE_BCNT_W-1:0] FULL_CNT = `TE_BMAP_W;

    // branch of the entry sitting in nc, recorded as it moves to tc
    logic                  stage_branch_q;
    logic                  stage_taken_q;
    logic [`TE_BCNT_W-1:0] count_q;
    logic [`TE_BMAP_W-1:0] map_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            stage_branch_q <= 1'b0;
            stage_taken_q  <= 1'b0;
            count_q        <= '0;
            map_q          <= '0;
        end else if (advance_i) begin
            stage_branch_q <= ibranch_i;
            stage_taken_q  <= itaken_i;
            if (flush_i) begin
                // old map leaves with the packet, arriving branch starts the next
                map_q   <= {{(`TE_BMAP_W-1){1'b0}}, stage_branch_q & stage_taken_q};
                count_q <= {{(`TE_BCNT_W-1){1'b0}}, stage_branch_q};
            end else if (stage_branch_q && !full_o) begin
                map_q[count_q] <= stage_taken_q;
                count_q        <= count_q + 1'b1;
            end
        end
    end

    assign empty_o = count_q == '0;
    assign full_o  = count_q == FULL_CNT;
    assign count_o = count_q;
    assign map_o   = map_q;

endmodule

/* rtl/te_hist_if.sv */
// history window flags
// last, this and next cycle view of the retirement window,
// from the history pipe to the priority block
`timescale 1ns/1ps

interface te_hist_if;
    // tc holds an entry
    logic valid;
    // last cycle
    logic lc_exception;
    logic lc_updiscon;
    logic lc_final_qualified;
    // this cycle
    logic tc_qualified;
    logic tc_exception;
    logic tc_retired;
    logic tc_first_qualified;
    logic tc_privchange;
    logic tc_enc_enabled;
    logic tc_enc_disabled;
    // next cycle lookahead
    logic nc_exception;
    logic nc_privchange;
    logic nc_qualified;
    logic nc_retired;

    modport driver (
        output valid, lc_exception, lc_updiscon, lc_final_qualified,
        output tc_qualified, tc_exception, tc_retired, tc_first_qualified,
        output tc_privchange, tc_enc_enabled, tc_enc_disabled,
        output nc_exception, nc_privchange, nc_qualified, nc_retired
    );

    modport receiver (
        input valid, lc_exception, lc_updiscon, lc_final_qualified,
        input tc_qualified, tc_exception, tc_retired, tc_first_qualified,
        input tc_privchange, tc_enc_enabled, tc_enc_disabled,
        input nc_exception, nc_privchange, nc_qualified, nc_retired
    );
endinterface

/* rtl/te_hist_pipe.sv */
// retirement history window
// three entry shift register (nc, tc, lc) stepped on each accepted
// retirement or enable change; an enable edge alone enters as a bubble
`timescale 1ns/1ps
`include "te_params.svh"

module te_hist_pipe (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  logic                   iretire_valid_i,
    input  logic                   stall_i,
    input  logic [`TE_IADDR_W-1:0] iaddr_i,
    input  logic                   iexception_i,
    input  logic                   iretired_i,
    input  logic                   iprivchange_i,
    input  logic                   iupdiscon_i,
    input  logic                   enc_enable_i,
    input  logic [`TE_CAUSE_W-1:0] icause_i,
    te_hist_if.driver              hist,
    output logic                   advance_o,
    output logic [`TE_IADDR_W-1:0] lc_addr_o,
    output logic [`TE_IADDR_W-1:0] tc_addr_o,
    output logic [`TE_CAUSE_W-1:0] lc_cause_o,
    output logic [`TE_CAUSE_W-1:0] tc_cause_o
);

    typedef struct packed {
        logic                   valid;
        logic                   qualified;
        logic                   exception;
        logic                   retired;
        logic                   privchange;
        logic                   updiscon;
        logic                   en_rise;
        logic                   en_fall;
        logic [`TE_IADDR_W-1:0] addr;
        logic [`TE_CAUSE_W-1:0] cause;
    } entry_t;

    entry_t nc_q;
    entry_t tc_q;
    entry_t lc_q;
    entry_t entry;
    logic   enable_q;
    logic   en_change;

    assign en_change = enc_enable_i ^ enable_q;
    // step on a retirement or an enable edge, held while the emitter stalls
    assign advance_o = ~stall_i & (iretire_valid_i | en_change);

    always_comb begin
        entry.valid      = 1'b1;
        // qualified only when enabled on both sides of the step
        entry.qualified  = iretire_valid_i & enc_enable_i & enable_q;
        entry.exception  = iretire_valid_i & iexception_i;
        entry.retired    = iretire_valid_i & iretired_i;
        entry.privchange = iretire_valid_i & iprivchange_i;
        entry.updiscon   = iretire_valid_i & iupdiscon_i;
        entry.en_rise    = enc_enable_i & ~enable_q;
        entry.en_fall    = ~enc_enable_i & enable_q;
        entry.addr       = iaddr_i;
        entry.cause      = icause_i;
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            nc_q     <= '0;
            tc_q     <= '0;
            lc_q     <= '0;
            enable_q <= 1'b0;
        end else if (advance_o) begin
            nc_q     <= entry;
            tc_q     <= nc_q;
            lc_q     <= tc_q;
            enable_q <= enc_enable_i;
        end
    end

    assign hist.valid              = tc_q.valid;
    assign hist.lc_exception       = lc_q.exception;
    assign hist.lc_updiscon        = lc_q.updiscon;
    // last qualified entry has just left tc
    assign hist.lc_final_qualified = lc_q.qualified & ~tc_q.qualified;
    assign hist.tc_qualified       = tc_q.qualified;
    assign hist.tc_exception       = tc_q.exception;
    assign hist.tc_retired         = tc_q.retired;
    assign hist.tc_first_qualified = tc_q.qualified & ~lc_q.qualified;
    assign hist.tc_privchange      = tc_q.privchange;
    assign hist.tc_enc_enabled     = tc_q.en_rise;
    assign hist.tc_enc_disabled    = tc_q.en_fall;
    assign hist.nc_exception       = nc_q.exception;
    assign hist.nc_privchange      = nc_q.privchange;
    assign hist.nc_qualified       = nc_q.qualified;
    assign hist.nc_retired         = nc_q.retired;

    // payload for the emitter
    assign lc_addr_o  = lc_q.addr;
    assign tc_addr_o  = tc_q.addr;
    assign lc_cause_o = lc_q.cause;
    assign tc_cause_o = tc_q.cause;

endmodule

/* rtl/te_packet_emitter.sv */
// packet emitter
// registers the requested packet with its payload on a window step
// and holds it on the output until the sink takes it
`timescale 1ns/1ps
`include "te_params.svh"

module te_packet_emitter (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  logic                   req_valid_i,
    input  te_pkg::te_format_e     format_i,
    input  te_pkg::te_sync_sf_e    subformat_i,
    input  logic                   thaddr_i,
    input  logic                   lc_tc_mux_i,
    input  te_pkg::te_qual_e       qual_i,
    input  logic [`TE_IADDR_W-1:0] lc_addr_i,
    input  logic [`TE_IADDR_W-1:0] tc_addr_i,
    input  logic [`TE_CAUSE_W-1:0] lc_cause_i,
    input  logic [`TE_CAUSE_W-1:0] tc_cause_i,
    input  logic [`TE_BCNT_W-1:0]  bmap_count_i,
    input  logic [`TE_BMAP_W-1:0]  bmap_i,
    input  logic                   advance_i,
    output logic                   stall_o,
    output logic                   flush_o,
    output logic                   pkt_valid_o,
    input  logic                   pkt_ready_i,
    output te_pkg::te_packet_t     pkt_o
);
    import te_pkg::*;

    logic       capture;
    logic       is_diff;
    te_packet_t pkt_d;

    assign capture = advance_i & req_valid_i;
    assign is_diff = format_i == F_DIFF_DELTA;
    // new packet due while the held one is still waiting
    assign stall_o = req_valid_i & pkt_valid_o & ~pkt_ready_i;
    // every packet but support restarts the branch map
    assign flush_o = capture & ~(format_i == F_SYNC && subformat_i == SF_SUPPORT);

    always_comb begin
        pkt_d.format    = format_i;
        pkt_d.subformat = subformat_i;
        pkt_d.thaddr    = thaddr_i;
        pkt_d.qual      = qual_i;
        pkt_d.addr      = lc_tc_mux_i ? tc_addr_i : lc_addr_i;
        pkt_d.cause     = lc_tc_mux_i ? tc_cause_i : lc_cause_i;
        // branches only travel in diff packets
        pkt_d.bcount    = is_diff ? bmap_count_i : '0;
        pkt_d.bmap      = is_diff ? bmap_i : '0;
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            pkt_valid_o <= 1'b0;
        end else if (capture) begin
            pkt_valid_o <= 1'b1;
        end else if (pkt_ready_i) begin
            pkt_valid_o <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (capture) begin
            pkt_o <= pkt_d;
        end
    end

endmodule

/* rtl/te_params.svh */
// trace encoder parameters
// field widths of the retirement port and packets, branch map depth
// and the forced sync period
`ifndef TE_PARAMS_SVH
`define TE_PARAMS_SVH

// instruction address and exception cause
`define TE_IADDR_W 32
`define TE_CAUSE_W 5

// branch map depth and branch count width
`define TE_BMAP_W 31
`define TE_BCNT_W 5

// window steps between forced sync packets
`define TE_RESYNC_MAX 64

`endif

/* rtl/te_pkg.sv */
// trace encoder package
// packet format encodings, sync subformats, qualification status
// and the packet record handed out by the emitter
`include "te_params.svh"

package te_pkg;

    // packet format, two bits on the trace
    typedef enum logic [1:0] {
        F_OPT_EXT    = 2'h0,
        F_DIFF_DELTA = 2'h1,
        F_ADDR_ONLY  = 2'h2,
        F_SYNC       = 2'h3
    } te_format_e;

    // subformat of format 3
    typedef enum logic [1:0] {
        SF_START   = 2'h0,
        SF_TRAP    = 2'h1,
        SF_CONTEXT = 2'h2,
        SF_SUPPORT = 2'h3
    } te_sync_sf_e;

    // qualification status carried by support packets
    typedef enum logic [1:0] {
        NO_CHANGE  = 2'h0,
        ENDED_REP  = 2'h1,
        TRACE_LOST = 2'h2,
        ENDED_NTR  = 2'h3
    } te_qual_e;

    // one packet, 80 bits
    typedef struct packed {
        te_format_e             format;
        te_sync_sf_e            subformat;
        logic                   thaddr;
        te_qual_e               qual;
        logic [`TE_IADDR_W-1:0] addr;
        logic [`TE_CAUSE_W-1:0] cause;
        logic [`TE_BCNT_W-1:0]  bcount;
        logic [`TE_BMAP_W-1:0]  bmap;
    } te_packet_t;

endpackage

/* rtl/te_priority.sv */
// packet priority
// picks the packet format for the entry in tc from the window flags,
// branch map state and resync counter, in the E-trace decision order
`timescale 1ns/1ps

module te_priority (
    input  logic                clk_i,
    input  logic                rst_ni,
    input  logic                advance_i,
    te_hist_if.receiver         hist,
    input  logic                bmap_empty_i,
    input  logic                bmap_full_i,
    input  logic                resync_et_i,
    input  logic                resync_gt_i,
    output logic                valid_o,
    output te_pkg::te_format_e  format_o,
    output te_pkg::te_sync_sf_e subformat_o,
    output logic                thaddr_o,
    output logic                lc_tc_mux_o,
    output logic                resync_rst_o,
    output te_pkg::te_qual_e    qual_status_o
);
    import te_pkg::*;

    logic       tc_exc_only;
    logic       tc_resync_br;
    logic       tc_er_n;
    logic       tc_support;
    logic       nc_exc_only;
    logic       nc_priv_br;
    logic       reported_q;
    logic       reported_d;
    logic       reported_upd;
    logic       ended_ntr_q;
    logic       ended_ntr_d;
    logic       ended_rep_q;
    logic       ended_rep_d;
    te_format_e br_format;

    assign tc_exc_only  = hist.tc_exception & ~hist.tc_retired;
    assign tc_resync_br = resync_et_i & ~bmap_empty_i;
    assign tc_er_n      = hist.tc_exception & hist.tc_retired;
    assign tc_support   = hist.tc_enc_enabled | hist.tc_enc_disabled | hist.lc_final_qualified;
    assign nc_exc_only  = hist.nc_exception & ~hist.nc_retired;
    assign nc_priv_br   = hist.nc_privchange & ~bmap_empty_i;
    // diff when branches are pending, else address only
    assign br_format    = bmap_empty_i ? F_ADDR_ONLY : F_DIFF_DELTA;

    // reported changes on an early trap or on a start
    assign reported_upd = valid_o && format_o == F_SYNC &&
        ((subformat_o == SF_TRAP && !thaddr_o) || (subformat_o == SF_START && !tc_exc_only));

    // state moves with the window so a stalled decision stays put
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            reported_q  <= 1'b0;
            ended_ntr_q <= 1'b0;
            ended_rep_q <= 1'b0;
        end else if (advance_i) begin
            if (reported_upd) begin
                reported_q <= reported_d;
            end
            ended_ntr_q <= ended_ntr_d;
            ended_rep_q <= ended_rep_d;
        end
    end

    always_comb begin
        valid_o       = 1'b0;
        format_o      = F_OPT_EXT;
        subformat_o   = SF_START;
        thaddr_o      = 1'b0;
        lc_tc_mux_o   = 1'b1;
        resync_rst_o  = 1'b0;
        qual_status_o = NO_CHANGE;
        reported_d    = 1'b0;
        ended_ntr_d   = 1'b0;
        ended_rep_d   = 1'b0;
        if (hist.valid && tc_support) begin
            // enable edge or end of qualification
            valid_o     = 1'b1;
            format_o    = F_SYNC;
            subformat_o = SF_SUPPORT;
            if (ended_ntr_q) begin
                qual_status_o = ENDED_NTR;
            end else if (ended_rep_q) begin
                qual_status_o = ENDED_REP;
            end
        end else if (hist.valid && hist.tc_qualified) begin
            valid_o = 1'b1;
            if (hist.lc_exception) begin
                format_o     = F_SYNC;
                resync_rst_o = 1'b1;
                if (tc_exc_only) begin
                    // handler traps at once, report lc cause now
                    subformat_o = SF_TRAP;
                    lc_tc_mux_o = 1'b0;
                    reported_d  = 1'b1;
                end else if (!reported_q) begin
                    subformat_o = SF_TRAP;
                    lc_tc_mux_o = 1'b0;
                    thaddr_o    = 1'b1;
                end
            end else if (hist.tc_first_qualified || hist.tc_privchange || resync_gt_i) begin
                format_o     = F_SYNC;
                resync_rst_o = 1'b1;
            end else if (hist.lc_updiscon) begin
                ended_ntr_d = 1'b1;
                if (tc_exc_only) begin
                    format_o     = F_SYNC;
                    subformat_o  = SF_TRAP;
                    resync_rst_o = 1'b1;
                end else begin
                    format_o = br_format;
                end
            end else if (tc_resync_br || tc_er_n || nc_exc_only || nc_priv_br ||
                         !hist.nc_qualified) begin
                // last qualified entry before tracing stops
                ended_rep_d = ~hist.nc_qualified;
                format_o    = br_format;
            end else if (bmap_full_i) begin
                format_o = F_DIFF_DELTA;
            end else begin
                valid_o = 1'b0;
            end
        end
    end

endmodule

/* rtl/te_resync_cnt.sv */
// resync counter
// counts window steps since the last sync packet, flags one step
// before the limit and at or past it
`timescale 1ns/1ps
`include "te_params.svh"

module te_resync_cnt (
    input  logic clk_i,
    input  logic rst_ni,
    input  logic advance_i,
    input  logic clear_i,
    output logic et_max_o,
    output logic gt_max_o
);

    localparam int CNT_W = $clog2(`TE_RESYNC_MAX) + 1;
    localparam logic [CNT_W-1:0] LIMIT = CNT_W'(`TE_RESYNC_MAX);

    logic [CNT_W-1:0] cnt_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            cnt_q <= '0;
        end else if (advance_i) begin
            if (clear_i) begin
                cnt_q <= '0;
            end else if (!gt_max_o) begin
                // stops at the limit until a sync clears it
                cnt_q <= cnt_q + 1'b1;
            end
        end
    end

    assign et_max_o = cnt_q == LIMIT - 1'b1;
    assign gt_max_o = cnt_q >= LIMIT;

endmodule

/* rtl/te_top.sv */
// instruction trace encoder
// one retired instruction per cycle in over valid/ready, E-trace
// style sync, diff and address packets out over valid/ready
`timescale 1ns/1ps
`include "te_params.svh"

module te_top (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  logic                   enc_enable_i,
    input  logic                   iretire_valid_i,
    output logic                   iretire_ready_o,
    input  logic [`TE_IADDR_W-1:0] iaddr_i,
    input  logic                   iexception_i,
    input  logic [`TE_CAUSE_W-1:0] icause_i,
    input  logic                   iprivchange_i,
    input  logic                   iupdiscon_i,
    input  logic                   ibranch_i,
    input  logic                   itaken_i,
    output logic                   pkt_valid_o,
    input  logic                   pkt_ready_i,
    output te_pkg::te_format_e     pkt_format_o,
    output te_pkg::te_sync_sf_e    pkt_subformat_o,
    output logic                   pkt_thaddr_o,
    output te_pkg::te_qual_e       pkt_qual_o,
    output logic [`TE_IADDR_W-1:0] pkt_addr_o,
    output logic [`TE_CAUSE_W-1:0] pkt_cause_o,
    output logic [`TE_BCNT_W-1:0]  pkt_bcount_o,
    output logic [`TE_BMAP_W-1:0]  pkt_bmap_o
);
    import te_pkg::*;

    logic                   advance;
    logic                   stall;
    logic                   flush;
    logic                   bmap_empty;
    logic                   bmap_full;
    logic [`TE_BCNT_W-1:0]  bmap_count;
    logic [`TE_BMAP_W-1:0]  bmap;
    logic                   resync_et;
    logic                   resync_gt;
    logic                   resync_rst;
    logic                   req_valid;
    te_format_e             req_format;
    te_sync_sf_e            req_subformat;
    logic                   req_thaddr;
    logic                   req_lc_tc_mux;
    te_qual_e               req_qual;
    logic [`TE_IADDR_W-1:0] lc_addr;
    logic [`TE_IADDR_W-1:0] tc_addr;
    logic [`TE_CAUSE_W-1:0] lc_cause;
    logic [`TE_CAUSE_W-1:0] tc_cause;
    te_packet_t             pkt;

    te_hist_if hist ();

    assign iretire_ready_o = ~stall;

    // exceptions on this port never retire
    te_hist_pipe u_hist (
        .clk_i(clk_i), .rst_ni(rst_ni),
        .iretire_valid_i(iretire_valid_i), .stall_i(stall),
        .iaddr_i(iaddr_i), .iexception_i(iexception_i), .iretired_i(~iexception_i),
        .iprivchange_i(iprivchange_i), .iupdiscon_i(iupdiscon_i),
        .enc_enable_i(enc_enable_i), .icause_i(icause_i),
        .hist(hist), .advance_o(advance),
        .lc_addr_o(lc_addr), .tc_addr_o(tc_addr),
        .lc_cause_o(lc_cause), .tc_cause_o(tc_cause)
    );

    // bubble steps carry no branch
    te_branch_map u_bmap (
        .clk_i(clk_i), .rst_ni(rst_ni), .advance_i(advance),
        .ibranch_i(ibranch_i & iretire_valid_i), .itaken_i(itaken_i),
        .flush_i(flush), .empty_o(bmap_empty), .full_o(bmap_full),
        .count_o(bmap_count), .map_o(bmap)
    );

    te_resync_cnt u_resync (
        .clk_i(clk_i), .rst_ni(rst_ni), .advance_i(advance),
        .clear_i(resync_rst), .et_max_o(resync_et), .gt_max_o(resync_gt)
    );

    te_priority u_prio (
        .clk_i(clk_i), .rst_ni(rst_ni), .advance_i(advance), .hist(hist),
        .bmap_empty_i(bmap_empty), .bmap_full_i(bmap_full),
        .resync_et_i(resync_et), .resync_gt_i(resync_gt),
        .valid_o(req_valid), .format_o(req_format), .subformat_o(req_subformat),
        .thaddr_o(req_thaddr), .lc_tc_mux_o(req_lc_tc_mux),
        .resync_rst_o(resync_rst), .qual_status_o(req_qual)
    );

    te_packet_emitter u_emit (
        .clk_i(clk_i), .rst_ni(rst_ni),
        .req_valid_i(req_valid), .format_i(req_format), .subformat_i(req_subformat),
        .thaddr_i(req_thaddr), .lc_tc_mux_i(req_lc_tc_mux), .qual_i(req_qual),
        .lc_addr_i(lc_addr), .tc_addr_i(tc_addr),
        .lc_cause_i(lc_cause), .tc_cause_i(tc_cause),
        .bmap_count_i(bmap_count), .bmap_i(bmap), .advance_i(advance),
        .stall_o(stall), .flush_o(flush),
        .pkt_valid_o(pkt_valid_o), .pkt_ready_i(pkt_ready_i), .pkt_o(pkt)
    );

    // packet fields onto the plain output ports
    assign pkt_format_o    = pkt.format;
    assign pkt_subformat_o = pkt.subformat;
    assign pkt_thaddr_o    = pkt.thaddr;
    assign pkt_qual_o      = pkt.qual;
    assign pkt_addr_o      = pkt.addr;
    assign pkt_cause_o     = pkt.cause;
    assign pkt_bcount_o    = pkt.bcount;
    assign pkt_bmap_o      = pkt.bmap;

endmodule

/* run.sh */
#!/bin/sh
# build and run the trace encoder testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f flist.f --top-module te_tb -o te_sim || exit 1
out=$(./obj_dir/te_sim)
echo "$out"
echo "$out" | grep -q "^Simulation passed$" && exit 0 || exit 1
